// ==== verilog/btc_defs.svh ====
// dimensions and widths of the 8x8 SPC product code decoder
// llr and extrinsic widths must stay small enough that a sum of three fits BTC_SUM_W
`ifndef BTC_DEFS_SVH
`define BTC_DEFS_SVH

// line length and number of lines
`define BTC_DIM     8

// soft values, signed, symmetric range
`define BTC_LLR_W   6
`define BTC_EXTR_W  6
`define BTC_SUM_W   8

// header and result fields
`define BTC_TAG_W   8
`define BTC_ITER_W  4
`define BTC_ERR_W   7

`endif

// ==== verilog/btc_pkg.sv ====
// shared packed types of the decoder
// positive llr means bit 0, line element 0 sits in the low bits
`default_nettype none

`include "btc_defs.svh"

package btc_pkg;

  // data bits of one frame, rows 0..6 x columns 0..6
  localparam int DATA_W = (`BTC_DIM - 1) * (`BTC_DIM - 1);

  typedef logic signed [`BTC_LLR_W-1:0]  llr_t;
  typedef logic signed [`BTC_EXTR_W-1:0] extr_t;

  typedef llr_t      [`BTC_DIM-1:0] llr_line_t;
  typedef extr_t     [`BTC_DIM-1:0] extr_line_t;
  typedef llr_line_t [`BTC_DIM-1:0] llr_frame_t;

  typedef struct packed {
    logic [`BTC_TAG_W-1:0]  tag;
    logic [`BTC_ITER_W-1:0] niter;
  } frame_hdr_t;

  // data is row-major, bit 0 is row 0 column 0
  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [`BTC_ERR_W-1:0] nerr;
    logic                  decfail;
    logic [`BTC_TAG_W-1:0] tag;
  } result_t;

endpackage

`default_nettype wire

// ==== verilog/btc_hs_rx.sv ====
// four-phase receiver, data must be stable while req is high
// ack stays low while ready is low, which stalls the sender
`default_nettype none

`include "btc_defs.svh"

module btc_hs_rx
  import btc_pkg::*;
#(
  parameter type payload_t = llr_line_t
)
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     req,
  output logic     ack,
  input  payload_t data,
  input  logic     ready,
  output logic     valid,
  output payload_t payload
);

  // ack low is the wait-for-req state, ack high waits for req to drop
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ack   <= 1'b0;
      valid <= 1'b0;
    end
    else begin
      valid <= 1'b0;
      if (!ack) begin
        if (req && ready) begin
          ack   <= 1'b1;
          valid <= 1'b1;
        end
      end
      else if (!req) begin
        ack <= 1'b0;
      end
    end
  end

  // capture together with the ack rise
  always_ff @(posedge iclk) begin
    if (!ack && req && ready) begin
      payload <= data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/btc_frame_loader.sv ====
// builds one frame from a header and eight llr lines, row 0 first
// lines before a header are refused, all input is refused while a frame waits
`default_nettype none

`include "btc_defs.svh"

module btc_frame_loader
  import btc_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       hdr_valid,
  input  frame_hdr_t hdr,
  output logic       hdr_ready,
  input  logic       line_valid,
  input  llr_line_t  line,
  output logic       line_ready,
  output logic       frame_valid,
  output frame_hdr_t frame_hdr,
  output llr_frame_t frame_llr,
  input  logic       frame_take
);

  localparam int IDX_W = $clog2(`BTC_DIM);

  logic             have_hdr;
  logic [IDX_W-1:0] line_cnt;

  // one header, then the lines of that header
  assign hdr_ready  = !have_hdr && !frame_valid;
  assign line_ready = have_hdr && !frame_valid;

  //--------------------------------------------------
  // fill control
  //--------------------------------------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      have_hdr    <= 1'b0;
      line_cnt    <= '0;
      frame_valid <= 1'b0;
    end
    else begin
      if (frame_take) begin
        frame_valid <= 1'b0;
      end
      if (hdr_valid && !have_hdr) begin
        have_hdr <= 1'b1;
      end
      if (line_valid && have_hdr) begin
        // counter wraps back to row 0 after the last line
        line_cnt <= line_cnt + 1'b1;
        if (line_cnt == IDX_W'(`BTC_DIM - 1)) begin
          have_hdr    <= 1'b0;
          frame_valid <= 1'b1;
        end
      end
    end
  end

  // frame store, one row slot per line
  always_ff @(posedge iclk) begin
    if (hdr_valid) begin
      frame_hdr <= hdr;
    end
    if (line_valid) begin
      frame_llr[line_cnt] <= line;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/btc_spc_decoder.sv ====
// min-sum extrinsic of one even-parity SPC line, alpha fixed at 3/4
// output registered, one cycle after the input
`default_nettype none

`include "btc_defs.svh"

module btc_spc_decoder
  import btc_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       in_valid,
  input  llr_line_t  in_llr,
  input  extr_line_t in_extr,
  output logic       out_valid,
  output extr_line_t out_extr
);

  localparam int IDX_W    = $clog2(`BTC_DIM);
  localparam int MAG_W    = `BTC_SUM_W - 1;
  localparam int SUM_MAX  = (1 << (`BTC_SUM_W - 1)) - 1;
  localparam int EXTR_MAX = (1 << (`BTC_EXTR_W - 1)) - 1;

  logic signed [`BTC_SUM_W-1:0] sum [`BTC_DIM];
  logic [`BTC_DIM-1:0]          sgn;
  logic [MAG_W-1:0]             mag [`BTC_DIM];
  logic [MAG_W-1:0]             min1;
  logic [MAG_W-1:0]             min2;
  logic [IDX_W-1:0]             min1_idx;
  logic                         parity;
  extr_line_t                   extr_c;

  //--------------------------------------------------
  // saturated sums, signs and magnitudes
  //--------------------------------------------------
  always_comb begin : sums
    logic signed [`BTC_SUM_W:0] wide;
    for (int i = 0; i < `BTC_DIM; i++) begin
      wide = $signed(in_llr[i]) + $signed(in_extr[i]);
      if (wide > SUM_MAX) begin
        sum[i] = `BTC_SUM_W'(SUM_MAX);
      end
      else if (wide < -SUM_MAX) begin
        sum[i] = `BTC_SUM_W'(-SUM_MAX);
      end
      else begin
        sum[i] = wide[`BTC_SUM_W-1:0];
      end
      sgn[i] = sum[i][`BTC_SUM_W-1];
      mag[i] = sgn[i] ? MAG_W'(-sum[i]) : MAG_W'(sum[i]);
    end
  end

  // two smallest magnitudes, index of the smallest
  always_comb begin : search
    min1     = '1;
    min2     = '1;
    min1_idx = '0;
    for (int i = 0; i < `BTC_DIM; i++) begin
      if (mag[i] < min1) begin
        min2     = min1;
        min1     = mag[i];
        min1_idx = IDX_W'(i);
      end
      else if (mag[i] < min2) begin
        min2 = mag[i];
      end
    end
    parity = ^sgn;
  end

  // excluding own position, scale by 3/4 rounded down, clip to extrinsic range
  always_comb begin : extr
    logic [MAG_W-1:0] other;
    logic [MAG_W-1:0] scaled;
    for (int i = 0; i < `BTC_DIM; i++) begin
      other  = (i == min1_idx) ? min2 : min1;
      scaled = other - (other >> 2);
      if (scaled > EXTR_MAX) begin
        scaled = MAG_W'(EXTR_MAX);
      end
      // sign product of the others is total parity minus own sign
      extr_c[i] = (parity ^ sgn[i]) ? -extr_t'(scaled) : extr_t'(scaled);
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_valid <= 1'b0;
    end
    else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge iclk) begin
    out_extr <= extr_c;
  end

endmodule

`default_nettype wire

// ==== verilog/btc_dec_engine.sv ====
// iterative row/column min-sum decoder for the 8x8 SPC product code
// niter 0 runs one iteration, no early stop, one frame at a time
// result valid 18*niter+2 cycles after frame_take
`default_nettype none

`include "btc_defs.svh"

module btc_dec_engine
  import btc_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       frame_valid,
  input  frame_hdr_t frame_hdr,
  input  llr_frame_t frame_llr,
  output logic       frame_take,
  output logic       res_valid,
  output result_t    res,
  input  logic       tx_ready
);

  localparam int IDX_W = $clog2(`BTC_DIM);
  localparam int PH_W  = IDX_W + 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ROW,
    ST_COL,
    ST_DONE
  } state_t;

  state_t                  state;
  logic [PH_W-1:0]         phase;
  logic [IDX_W-1:0]        phase_idx;
  logic [`BTC_ITER_W-1:0]  iter;
  logic [`BTC_ITER_W-1:0]  last_iter;
  llr_frame_t              llr_q;
  frame_hdr_t              hdr_q;
  extr_line_t              row_extr [`BTC_DIM];
  extr_line_t              col_extr [`BTC_DIM];
  // write-back alignment with the spc register stage
  logic                    wr_col;
  logic [IDX_W-1:0]        wr_idx;
  logic                    spc_valid;
  llr_line_t               spc_llr;
  extr_line_t              spc_extr;
  logic                    spc_out_valid;
  extr_line_t              spc_out_extr;
  logic [DATA_W-1:0]       data_bits;
  logic [`BTC_ERR_W-1:0]   err_cnt;
  logic                    dec_fail;

  assign frame_take = (state == ST_IDLE) && frame_valid;
  assign phase_idx  = phase[IDX_W-1:0];
  assign last_iter  = (hdr_q.niter == '0) ? '0 : hdr_q.niter - 1'b1;

  //--------------------------------------------------
  // pass control
  //--------------------------------------------------
  // phase 0..7 issues a line, phase 8 waits for the last spc result
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= ST_IDLE;
      phase     <= '0;
      iter      <= '0;
      res_valid <= 1'b0;
      wr_col    <= 1'b0;
      wr_idx    <= '0;
    end
    else begin
      wr_col <= (state == ST_COL);
      wr_idx <= phase_idx;
      case (state)
        ST_IDLE: begin
          if (frame_valid) begin
            state <= ST_ROW;
            phase <= '0;
            iter  <= '0;
          end
        end
        ST_ROW: begin
          if (phase == PH_W'(`BTC_DIM)) begin
            state <= ST_COL;
            phase <= '0;
          end
          else begin
            phase <= phase + 1'b1;
          end
        end
        ST_COL: begin
          if (phase == PH_W'(`BTC_DIM)) begin
            phase <= '0;
            if (iter == last_iter) begin
              state <= ST_DONE;
            end
            else begin
              state <= ST_ROW;
              iter  <= iter + 1'b1;
            end
          end
          else begin
            phase <= phase + 1'b1;
          end
        end
        default: begin
          // first done cycle builds the result, then hold until the sender takes it
          if (!res_valid) begin
            res_valid <= 1'b1;
          end
          else if (tx_ready) begin
            res_valid <= 1'b0;
            state     <= ST_IDLE;
          end
        end
      endcase
    end
  end

  //--------------------------------------------------
  // line feed, columns read transposed
  //--------------------------------------------------
  assign spc_valid = ((state == ST_ROW) || (state == ST_COL)) && !phase[PH_W-1];

  always_comb begin
    for (int k = 0; k < `BTC_DIM; k++) begin
      if (state == ST_COL) begin
        spc_llr[k]  = llr_q[k][phase_idx];
        spc_extr[k] = row_extr[k][phase_idx];
      end
      else begin
        spc_llr[k]  = llr_q[phase_idx][k];
        spc_extr[k] = col_extr[phase_idx][k];
      end
    end
  end

  btc_spc_decoder spc (
    .iclk      (iclk),
    .ireset    (ireset),
    .in_valid  (spc_valid),
    .in_llr    (spc_llr),
    .in_extr   (spc_extr),
    .out_valid (spc_out_valid),
    .out_extr  (spc_out_extr)
  );

  // frame copy and extrinsic store, both arrays kept row-major
  always_ff @(posedge iclk) begin
    if (frame_take) begin
      llr_q <= frame_llr;
      hdr_q <= frame_hdr;
      for (int r = 0; r < `BTC_DIM; r++) begin
        row_extr[r] <= '0;
        col_extr[r] <= '0;
      end
    end
    else if (spc_out_valid) begin
      if (wr_col) begin
        for (int r = 0; r < `BTC_DIM; r++) begin
          col_extr[r][wr_idx] <= spc_out_extr[r];
        end
      end
      else begin
        row_extr[wr_idx] <= spc_out_extr;
      end
    end
  end

  //--------------------------------------------------
  // hard decision, error count, parity check
  //--------------------------------------------------
  always_comb begin : decide
    logic signed [`BTC_SUM_W-1:0] tot;
    logic                         hard_bit;
    logic [`BTC_DIM-1:0]          row_par;
    logic [`BTC_DIM-1:0]          col_par;
    err_cnt   = '0;
    row_par   = '0;
    col_par   = '0;
    data_bits = '0;
    for (int r = 0; r < `BTC_DIM; r++) begin
      for (int c = 0; c < `BTC_DIM; c++) begin
        tot = $signed(llr_q[r][c]) + $signed(row_extr[r][c]) + $signed(col_extr[r][c]);
        hard_bit = tot[`BTC_SUM_W-1];
        // against the sign of the channel llr
        if (hard_bit != llr_q[r][c][`BTC_LLR_W-1]) begin
          err_cnt = err_cnt + 1'b1;
        end
        row_par[r] = row_par[r] ^ hard_bit;
        col_par[c] = col_par[c] ^ hard_bit;
        if ((r < `BTC_DIM - 1) && (c < `BTC_DIM - 1)) begin
          data_bits[r * (`BTC_DIM - 1) + c] = hard_bit;
        end
      end
    end
    dec_fail = |{row_par, col_par};
  end

  always_ff @(posedge iclk) begin
    if ((state == ST_DONE) && !res_valid) begin
      res.data    <= data_bits;
      res.nerr    <= err_cnt;
      res.decfail <= dec_fail;
      res.tag     <= hdr_q.tag;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/btc_result_tx.sv ====
// four-phase sender with a one-entry holding register
// a new result is taken only after ack of the previous one is low again
`default_nettype none

`include "btc_defs.svh"

module btc_result_tx
  import btc_pkg::*;
(
  input  logic    iclk,
  input  logic    ireset,
  input  logic    res_valid,
  input  result_t res_in,
  output logic    tx_ready,
  output logic    req,
  input  logic    ack,
  output result_t res
);

  logic full;

  assign tx_ready = !full;

  // full and req raised together, req drops on ack, full clears on ack low
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      full <= 1'b0;
      req  <= 1'b0;
    end
    else if (!full) begin
      if (res_valid) begin
        full <= 1'b1;
        req  <= 1'b1;
      end
    end
    else if (req) begin
      if (ack) begin
        req <= 1'b0;
      end
    end
    else if (!ack) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge iclk) begin
    if (res_valid && !full) begin
      res <= res_in;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/btc_dec_top.sv ====
// 8x8 SPC product code decoder with four-phase header, line and result channels
// the loader fills the next frame while the engine decodes the current one
`default_nettype none

`include "btc_defs.svh"

module btc_dec_top
  import btc_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       hdr_req,
  output logic       hdr_ack,
  input  frame_hdr_t hdr,
  input  logic       line_req,
  output logic       line_ack,
  input  llr_line_t  line,
  output logic       res_req,
  input  logic       res_ack,
  output result_t    res
);

  logic       hdr_valid;
  logic       hdr_ready;
  frame_hdr_t hdr_data;
  logic       line_valid;
  logic       line_ready;
  llr_line_t  line_data;
  logic       frame_valid;
  logic       frame_take;
  frame_hdr_t frame_hdr;
  llr_frame_t frame_llr;
  logic       res_valid;
  logic       tx_ready;
  result_t    res_data;

  //--------------------------------------------------
  // input channels
  //--------------------------------------------------
  btc_hs_rx #(.payload_t(frame_hdr_t)) hdr_rx (
    .iclk    (iclk),
    .ireset  (ireset),
    .req     (hdr_req),
    .ack     (hdr_ack),
    .data    (hdr),
    .ready   (hdr_ready),
    .valid   (hdr_valid),
    .payload (hdr_data)
  );

  btc_hs_rx #(.payload_t(llr_line_t)) line_rx (
    .iclk    (iclk),
    .ireset  (ireset),
    .req     (line_req),
    .ack     (line_ack),
    .data    (line),
    .ready   (line_ready),
    .valid   (line_valid),
    .payload (line_data)
  );

  btc_frame_loader loader (
    .iclk        (iclk),
    .ireset      (ireset),
    .hdr_valid   (hdr_valid),
    .hdr         (hdr_data),
    .hdr_ready   (hdr_ready),
    .line_valid  (line_valid),
    .line        (line_data),
    .line_ready  (line_ready),
    .frame_valid (frame_valid),
    .frame_hdr   (frame_hdr),
    .frame_llr   (frame_llr),
    .frame_take  (frame_take)
  );

  //--------------------------------------------------
  // decode and result channel
  //--------------------------------------------------
  btc_dec_engine engine (
    .iclk        (iclk),
    .ireset      (ireset),
    .frame_valid (frame_valid),
    .frame_hdr   (frame_hdr),
    .frame_llr   (frame_llr),
    .frame_take  (frame_take),
    .res_valid   (res_valid),
    .res         (res_data),
    .tx_ready    (tx_ready)
  );

  btc_result_tx res_tx (
    .iclk      (iclk),
    .ireset    (ireset),
    .res_valid (res_valid),
    .res_in    (res_data),
    .tx_ready  (tx_ready),
    .req       (res_req),
    .ack       (res_ack),
    .res       (res)
  );

endmodule

`default_nettype wire

// ==== test/tb_btc_dec.sv ====
// directed tests of the 8x8 SPC product code decoder
// codewords are built here from random data, llr magnitude 31 unless a test flips a bit
// every wait is bounded by TIMEOUT cycles
`default_nettype none

`include "btc_defs.svh"

module tb_btc_dec
  import btc_pkg::*;
();

  localparam int N       = `BTC_DIM;
  localparam int K       = `BTC_DIM - 1;
  localparam int TIMEOUT = 2000;
  localparam logic [15:0] LFSR_SEED = 16'd60489;

  logic       iclk;
  logic       ireset;
  logic       hdr_req;
  logic       hdr_ack;
  frame_hdr_t hdr;
  logic       line_req;
  logic       line_ack;
  llr_line_t  line;
  logic       res_req;
  logic       res_ack;
  result_t    res;
  logic [15:0] lfsr;

  btc_dec_top UUT (
    .iclk     (iclk),
    .ireset   (ireset),
    .hdr_req  (hdr_req),
    .hdr_ack  (hdr_ack),
    .hdr      (hdr),
    .line_req (line_req),
    .line_ack (line_ack),
    .line     (line),
    .res_req  (res_req),
    .res_ack  (res_ack),
    .res      (res)
  );

  always #50 iclk = ~iclk;

  //--------------------------------------------------
  // random bits and codeword model
  //--------------------------------------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit, first bit ends up as the msb
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  // 7x7 data plus even parity row and column, bit r*8+c
  function automatic logic [63:0] encode(input logic [48:0] d);
    logic [63:0] cw;
    logic        p;
    cw = '0;
    for (int r = 0; r < K; r++) begin
      p = 1'b0;
      for (int c = 0; c < K; c++) begin
        cw[r*N+c] = d[r*K+c];
        p = p ^ d[r*K+c];
      end
      cw[r*N+K] = p;
    end
    // parity row, corner included
    for (int c = 0; c < N; c++) begin
      p = 1'b0;
      for (int r = 0; r < K; r++) begin
        p = p ^ cw[r*N+c];
      end
      cw[K*N+c] = p;
    end
    return cw;
  endfunction

  // bit 1 maps to a negative llr
  function automatic llr_frame_t to_llr(input logic [63:0] cw);
    llr_frame_t f;
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        f[r][c] = cw[r*N+c] ? llr_t'(-31) : llr_t'(31);
      end
    end
    return f;
  endfunction

  // wrong sign at pos with the given magnitude
  function automatic llr_frame_t flip(input llr_frame_t f, input int pos, input int mag);
    llr_frame_t g;
    g = f;
    if (f[pos/N][pos%N][`BTC_LLR_W-1]) begin
      g[pos/N][pos%N] = llr_t'(mag);
    end
    else begin
      g[pos/N][pos%N] = llr_t'(-mag);
    end
    return g;
  endfunction

  // data bits as read from the input signs
  function automatic logic [48:0] input_data(input llr_frame_t f);
    logic [48:0] d;
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K; c++) begin
        d[r*K+c] = f[r][c][`BTC_LLR_W-1];
      end
    end
    return d;
  endfunction

  //--------------------------------------------------
  // checks and failure exit
  //--------------------------------------------------
  task automatic fail_run(input string why);
    $display("Simulation failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  task automatic check_result(input result_t r, input logic [48:0] d, input int nerr,
                              input logic decfail, input logic [7:0] tag);
    check("res.data", 64'(r.data), 64'(d));
    check("res.nerr", 64'(r.nerr), 64'(nerr));
    check("res.decfail", 64'(r.decfail), 64'(decfail));
    check("res.tag", 64'(r.tag), 64'(tag));
  endtask

  // 0 hdr_ack, 1 line_ack, 2 res_req
  function automatic logic chan_level(input int sel);
    case (sel)
      0: return hdr_ack;
      1: return line_ack;
      default: return res_req;
    endcase
  endfunction

  // sampled on the falling edge
  task automatic wait_for_level(input int sel, input logic level, input string what);
    int n;
    n = 0;
    @(negedge iclk);
    while (chan_level(sel) !== level) begin
      n++;
      if (n > TIMEOUT) begin
        fail_run({"timeout waiting for ", what});
      end
      else begin
        @(negedge iclk);
      end
    end
  endtask

  //--------------------------------------------------
  // four-phase channel tasks
  //--------------------------------------------------
  task automatic send_hdr(input logic [7:0] tag, input logic [3:0] niter);
    frame_hdr_t h;
    h.tag   = tag;
    h.niter = niter;
    @(posedge iclk);
    hdr     <= h;
    hdr_req <= 1'b1;
    wait_for_level(0, 1'b1, "hdr_ack high");
    @(posedge iclk);
    hdr_req <= 1'b0;
    wait_for_level(0, 1'b0, "hdr_ack low");
  endtask

  task automatic send_line(input llr_line_t l);
    @(posedge iclk);
    line     <= l;
    line_req <= 1'b1;
    wait_for_level(1, 1'b1, "line_ack high");
    @(posedge iclk);
    line_req <= 1'b0;
    wait_for_level(1, 1'b0, "line_ack low");
  endtask

  task automatic send_frame(input logic [7:0] tag, input logic [3:0] niter,
                            input llr_frame_t f);
    send_hdr(tag, niter);
    for (int r = 0; r < N; r++) begin
      send_line(f[r]);
    end
  endtask

  // ack delay of up to 2^delay_bits-1 cycles
  task automatic get_result(input int delay_bits, output result_t r);
    logic [63:0] v;
    int          delay;
    wait_for_level(2, 1'b1, "res_req high");
    r = res;
    take_bits(delay_bits, v);
    delay = int'(v[7:0]);
    repeat (delay) @(posedge iclk);
    @(posedge iclk);
    res_ack <= 1'b1;
    wait_for_level(2, 1'b0, "res_req low");
    @(posedge iclk);
    res_ack <= 1'b0;
  endtask

  //--------------------------------------------------
  // directed tests
  //--------------------------------------------------
  task automatic check_quiet();
    check("hdr_ack", 64'(hdr_ack), 64'(0));
    check("line_ack", 64'(line_ack), 64'(0));
    check("res_req", 64'(res_req), 64'(0));
  endtask

  // reset held for 16 rising edges
  task automatic test_reset();
    repeat (15) begin
      @(negedge iclk);
      check_quiet();
    end
    @(posedge iclk);
    ireset <= 1'b0;
    repeat (4) begin
      @(negedge iclk);
      check_quiet();
    end
  endtask

  task automatic test_clean(input int count);
    logic [63:0] v;
    logic [48:0] d;
    logic [3:0]  niter;
    result_t     r;
    for (int i = 0; i < count; i++) begin
      take_bits(49, v);
      d = v[48:0];
      take_bits(2, v);
      niter = 4'(v[1:0] % 3 + 1);
      send_frame(8'(8'h10 + i), niter, to_llr(encode(d)));
      get_result(3, r);
      check_result(r, d, 0, 1'b0, 8'(8'h10 + i));
    end
  endtask

  // one weak or strong wrong sign, corrected in one iteration
  task automatic test_single_error(input int count);
    logic [63:0] v;
    logic [48:0] d;
    int          pos;
    int          mag;
    result_t     r;
    for (int i = 0; i < count; i++) begin
      take_bits(49, v);
      d = v[48:0];
      take_bits(6, v);
      pos = int'(v[5:0]);
      take_bits(5, v);
      mag = int'(v[4:0]) % 31 + 1;
      send_frame(8'(8'h40 + i), 4'd1, flip(to_llr(encode(d)), pos, mag));
      get_result(3, r);
      check_result(r, d, 1, 1'b0, 8'(8'h40 + i));
    end
  endtask

  // two strong errors in one row keep the row even, so the hard bits stay as received
  task automatic test_double_error(input int count);
    logic [63:0] v;
    logic [48:0] d;
    int          row;
    int          c1;
    int          c2;
    llr_frame_t  f;
    result_t     r;
    for (int i = 0; i < count; i++) begin
      take_bits(49, v);
      d = v[48:0];
      take_bits(3, v);
      row = int'(v[2:0]);
      take_bits(3, v);
      c1 = int'(v[2:0]);
      take_bits(3, v);
      c2 = (c1 + 1 + int'(v[2:0]) % 7) % N;
      f = flip(to_llr(encode(d)), row*N + c1, 31);
      f = flip(f, row*N + c2, 31);
      send_frame(8'(8'h80 + i), 4'd1, f);
      get_result(3, r);
      check_result(r, input_data(f), 0, 1'b1, 8'(8'h80 + i));
    end
  endtask

  // sender and receiver run side by side, ack delayed up to 15 cycles
  task automatic test_back_to_back();
    logic [63:0] v;
    logic [48:0] exp_d [3];
    logic [3:0]  niter [3];
    llr_frame_t  f [3];
    result_t     r;
    for (int i = 0; i < 3; i++) begin
      take_bits(49, v);
      exp_d[i] = v[48:0];
      take_bits(2, v);
      niter[i] = 4'(v[1:0] % 3 + 1);
      f[i] = to_llr(encode(exp_d[i]));
    end
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          send_frame(8'(8'hc0 + i), niter[i], f[i]);
        end
      end
      begin
        for (int i = 0; i < 3; i++) begin
          get_result(4, r);
          check_result(r, exp_d[i], 0, 1'b0, 8'(8'hc0 + i));
        end
      end
    join
    // no extra result may follow
    repeat (100) begin
      @(negedge iclk);
      check("res_req", 64'(res_req), 64'(0));
    end
  endtask

  //--------------------------------------------------
  // main sequence
  //--------------------------------------------------
  initial begin
    iclk     = 1'b0;
    lfsr     = LFSR_SEED;
    ireset   <= 1'b1;
    hdr_req  <= 1'b0;
    hdr      <= '0;
    line_req <= 1'b0;
    line     <= '0;
    res_ack  <= 1'b0;
    test_reset();
    test_clean(6);
    test_single_error(8);
    test_double_error(4);
    test_back_to_back();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/btc_pkg.sv
verilog/btc_hs_rx.sv
verilog/btc_frame_loader.sv
verilog/btc_spc_decoder.sv
verilog/btc_dec_engine.sv
verilog/btc_result_tx.sv
verilog/btc_dec_top.sv
test/tb_btc_dec.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sources.f --top-module tb_btc_dec -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_btc_dec
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0
